// File: rapcore_config.svh
`ifndef RAPCORE_CONFIG_SVH
`define RAPCORE_CONFIG_SVH

// Number of step/dir/enable channels
`define MOTOR_COUNT 2

// Width of a move duration in CLK ticks
`define MOVE_DURATION_BITS 32

// Moves the FIFO can hold ahead of the step generator
`define BUFFER_SIZE 4

`endif

// File: rapcore_pkg.sv
`include "rapcore_config.svh"

package rapcore_pkg;

  // Opcode in bits 7:0 of a command header word
  typedef enum logic [7:0] {
    cmd_move   = 8'd1,
    cmd_enable = 8'd2,
    cmd_status = 8'd3   // No-op, only fetches the reply
  } cmd_e;

  localparam int motor_count   = `MOTOR_COUNT;
  localparam int duration_bits = `MOVE_DURATION_BITS;
  localparam int buffer_size   = `BUFFER_SIZE;
  localparam int incr_bits     = 32;

  // Packed move: directions at the bottom, then increments, duration on top
  localparam int dir_lsb    = 0;
  localparam int incr_lsb   = dir_lsb + motor_count;
  localparam int dur_lsb    = incr_lsb + motor_count * incr_bits;
  localparam int move_width = dur_lsb + duration_bits;

endpackage

// File: spi_word.sv
`timescale 1ns/1ps

module spi_word (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        SCK,
  input  logic        CS,
  input  logic        COPI,
  input  logic [63:0] status_word,
  input  logic        word_ack,
  output logic        CIPO,
  output logic        word_req,
  output logic [63:0] word_data
);

  logic [2:0]  sck_sync;   // Two sync flops plus one for edge detect
  logic [2:0]  cs_sync;
  logic [1:0]  copi_sync;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_active;
  logic        cs_start;   // First cycle CS is seen low
  logic [5:0]  bit_cnt;    // Wire position inside the word
  logic [5:0]  bit_idx;    // Word bit at that wire position
  logic [63:0] rx_word;
  logic [63:0] rx_next;
  logic [63:0] tx_word;
  logic        word_last;
  logic        word_take;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], SCK};
      cs_sync   <= {cs_sync[1:0], CS};
      copi_sync <= {copi_sync[0], COPI};
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_active = ~cs_sync[1];
  assign cs_start  = ~cs_sync[1] & cs_sync[2];

  // Bytes go LSB byte first, each byte MSB first
  assign bit_idx   = {bit_cnt[5:3], ~bit_cnt[2:0]};
  assign word_last = cs_active && sck_rise && (bit_cnt == 6'd63);
  assign word_take = word_last && !word_req && !word_ack;

  always_comb begin
    rx_next          = rx_word;
    rx_next[bit_idx] = copi_sync[1];
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
    end else if (!cs_active) begin
      bit_cnt <= '0;
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 6'd1;  // Wraps to the next word
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_word <= rx_next;
    end
    if (word_take) begin
      word_data <= rx_next;
    end
    if (cs_start) begin
      tx_word <= status_word;  // Snapshot of the reply
    end
  end

  // Four-phase handshake towards the decoder
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_req <= 1'b0;
    end else if (word_take) begin
      word_req <= 1'b1;
    end else if (word_req && word_ack) begin
      word_req <= 1'b0;
    end
  end

  // Mode 0, first bit out before the first rising edge
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      CIPO <= 1'b0;
    end else if (cs_start) begin
      CIPO <= status_word[7];
    end else if (!cs_active) begin
      CIPO <= 1'b0;
    end else if (sck_fall) begin
      CIPO <= tx_word[bit_idx];
    end
  end

  // Decoder must close the handshake before the next word completes
  a_word_not_dropped: assert property (@(posedge CLK) disable iff (!resetn)
    word_last |-> (!word_req && !word_ack));

endmodule

// File: command_decoder.sv
`timescale 1ns/1ps

module command_decoder import rapcore_pkg::*; (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   word_req,
  input  logic [63:0]            word_data,
  input  logic                   buffer_dtr,
  input  logic [7:0]             fill,
  input  logic                   busy,
  input  logic                   move_done,
  input  logic                   halt,
  output logic                   word_ack,
  output logic                   push,
  output logic [move_width-1:0]  push_data,
  output logic [motor_count-1:0] enable_mask,
  output logic [63:0]            status_word
);

  localparam int idx_bits = (motor_count > 1) ? $clog2(motor_count) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_collect,
    st_push
  } state_e;

  state_e              state;
  logic [idx_bits-1:0] incr_idx;    // Next increment word of the move
  logic [31:0]         done_count;  // Completed moves, wraps
  logic                take_word;
  logic                last_incr;
  cmd_e                opcode;

  // Holding off here stalls the SPI side while the buffer is full
  assign take_word = word_req && !word_ack && (state != st_push);
  assign last_incr = (incr_idx == idx_bits'(motor_count - 1));
  assign opcode    = cmd_e'(word_data[7:0]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_ack <= 1'b0;
    end else if (word_ack && !word_req) begin
      word_ack <= 1'b0;
    end else if (take_word) begin
      word_ack <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state       <= st_idle;
      incr_idx    <= '0;
      push        <= 1'b0;
      enable_mask <= '0;
    end else begin
      push <= 1'b0;
      case (state)
        st_idle: begin
          if (take_word) begin
            case (opcode)
              cmd_move: begin
                state    <= st_collect;
                incr_idx <= '0;
              end
              cmd_enable: enable_mask <= word_data[8 +: motor_count];
              cmd_status: begin
                // Reply already sits in status_word
              end
              default: begin
                // Unknown opcode, acked and dropped
              end
            endcase
          end
        end
        st_collect: begin
          if (take_word) begin
            if (last_incr) begin
              state <= st_push;
            end else begin
              incr_idx <= incr_idx + 1'b1;
            end
          end
        end
        st_push: begin
          if (buffer_dtr) begin
            push  <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      if (halt) begin
        state <= st_idle;  // Partial move is abandoned
        push  <= 1'b0;
      end
    end
  end

  // Move assembly
  always_ff @(posedge CLK) begin
    if (take_word) begin
      if (state == st_idle && opcode == cmd_move) begin
        push_data[dir_lsb +: motor_count]   <= word_data[8 +: motor_count];
        push_data[dur_lsb +: duration_bits] <= word_data[32 +: duration_bits];
      end else if (state == st_collect) begin
        push_data[incr_lsb + incr_idx * incr_bits +: incr_bits] <= word_data[incr_bits-1:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      done_count <= '0;
    end else if (move_done) begin
      done_count <= done_count + 32'd1;
    end
  end

  assign status_word = {16'h0000, done_count, 7'b0000000, busy, fill};

endmodule

// File: move_buffer.sv
`timescale 1ns/1ps

module move_buffer import rapcore_pkg::*; (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  push,
  input  logic [move_width-1:0] push_data,
  input  logic                  pop,
  input  logic                  halt,
  output logic                  pop_valid,
  output logic [move_width-1:0] pop_data,
  output logic                  buffer_dtr,
  output logic [7:0]            fill
);

  localparam int ptr_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1;
  localparam int cnt_bits = $clog2(buffer_size + 1);

  logic [move_width-1:0] mem [buffer_size];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [cnt_bits-1:0]   count;
  logic                  do_push;
  logic                  do_pop;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(buffer_size - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && buffer_dtr && !halt;  // Halt flush wins
  assign do_pop  = pop && pop_valid && !halt;

  always_ff @(posedge CLK) begin
    if (!resetn || halt) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];
  assign buffer_dtr = (count != cnt_bits'(buffer_size));  // Room for one more
  assign fill       = 8'(count);

  // Decoder waits on buffer_dtr, step generator on pop_valid
  a_no_push_full: assert property (@(posedge CLK) disable iff (!resetn)
    push |-> buffer_dtr);
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (!resetn)
    pop |-> pop_valid);

endmodule

// File: step_generator.sv
`timescale 1ns/1ps

module step_generator import rapcore_pkg::*; (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   pop_valid,
  input  logic [move_width-1:0]  pop_data,
  input  logic                   halt,
  output logic                   pop,
  output logic                   busy,
  output logic                   move_done,
  output logic [motor_count-1:0] step,
  output logic [motor_count-1:0] dir
);

  logic [duration_bits-1:0] remaining;  // Ticks left in the move
  logic [duration_bits-1:0] pop_duration;
  logic [incr_bits-1:0]     incr [motor_count];
  logic [incr_bits-1:0]     acc [motor_count];
  logic [incr_bits-1:0]     acc_next [motor_count];
  logic [motor_count-1:0]   carry;
  logic [motor_count-1:0]   incr_msb;
  logic                     tick;

  assign pop          = !busy && pop_valid && !halt;
  assign tick         = busy && !halt;
  assign pop_duration = pop_data[dur_lsb +: duration_bits];
  assign step         = tick ? carry : '0;  // Carry out of the DDA add

  always_comb begin
    logic [incr_bits:0] sum;
    for (int m = 0; m < motor_count; m++) begin
      sum         = {1'b0, acc[m]} + {1'b0, incr[m]};
      carry[m]    = sum[incr_bits];
      acc_next[m] = sum[incr_bits-1:0];
      incr_msb[m] = pop_data[incr_lsb + m * incr_bits + incr_bits - 1];
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      move_done <= 1'b0;
      remaining <= '0;
      dir       <= '0;
    end else begin
      move_done <= 1'b0;
      if (halt) begin
        busy <= 1'b0;  // No done pulse for a halted move
      end else if (pop) begin
        dir       <= pop_data[dir_lsb +: motor_count];
        remaining <= pop_duration;
        if (pop_duration == '0) begin
          move_done <= 1'b1;  // Empty move finishes at once
        end else begin
          busy <= 1'b1;
        end
      end else if (tick) begin
        remaining <= remaining - 1'b1;
        if (remaining == duration_bits'(1)) begin
          busy      <= 1'b0;
          move_done <= 1'b1;
        end
      end
    end
  end

  // Accumulators restart with every move
  always_ff @(posedge CLK) begin
    for (int m = 0; m < motor_count; m++) begin
      if (pop) begin
        incr[m] <= pop_data[incr_lsb + m * incr_bits +: incr_bits];
        acc[m]  <= '0;
      end else if (tick) begin
        acc[m] <= acc_next[m];
      end
    end
  end

  // Host increments must stay below half a turn or pulses merge
  a_incr_range: assert property (@(posedge CLK) disable iff (!resetn)
    pop |-> (incr_msb == '0));

endmodule

// File: rapcore.sv
`timescale 1ns/1ps

module rapcore import rapcore_pkg::*; (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   SCK,
  input  logic                   CS,
  input  logic                   COPI,
  input  logic                   HALT,
  output logic                   CIPO,
  output logic [motor_count-1:0] STEPOUTPUT,
  output logic [motor_count-1:0] DIROUTPUT,
  output logic [motor_count-1:0] ENOUTPUT,
  output logic                   BUFFER_DTR,
  output logic                   MOVE_DONE
);

  logic [63:0]           status_word;
  logic [63:0]           word_data;
  logic                  word_req;
  logic                  word_ack;
  logic                  push;
  logic [move_width-1:0] push_data;
  logic                  pop;
  logic                  pop_valid;
  logic [move_width-1:0] pop_data;
  logic [7:0]            fill;
  logic                  busy;

  spi_word u_spi_word (
    .CLK         (CLK),
    .resetn      (resetn),
    .SCK         (SCK),
    .CS          (CS),
    .COPI        (COPI),
    .status_word (status_word),
    .word_ack    (word_ack),
    .CIPO        (CIPO),
    .word_req    (word_req),
    .word_data   (word_data)
  );

  command_decoder u_command_decoder (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_req    (word_req),
    .word_data   (word_data),
    .buffer_dtr  (BUFFER_DTR),
    .fill        (fill),
    .busy        (busy),
    .move_done   (MOVE_DONE),
    .halt        (HALT),
    .word_ack    (word_ack),
    .push        (push),
    .push_data   (push_data),
    .enable_mask (ENOUTPUT),
    .status_word (status_word)
  );

  move_buffer u_move_buffer (
    .CLK        (CLK),
    .resetn     (resetn),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .halt       (HALT),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .buffer_dtr (BUFFER_DTR),
    .fill       (fill)
  );

  step_generator u_step_generator (
    .CLK       (CLK),
    .resetn    (resetn),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .halt      (HALT),
    .pop       (pop),
    .busy      (busy),
    .move_done (MOVE_DONE),
    .step      (STEPOUTPUT),
    .dir       (DIROUTPUT)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic resetn
);

  localparam realtime half_period = 2.0;  // 4 ns CLK

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge CLK);
    #1 resetn = 1'b1;  // Released just after the second edge
  end

endmodule

// File: tb_rapcore.sv
`timescale 1ns/1ps

module tb_rapcore import rapcore_pkg::*; ();

  localparam int half_clks = 5;       // CLK per SCK half period
  localparam int limit     = 400000;  // Cycle budget of every wait

  logic                   CLK;
  logic                   resetn;
  logic                   SCK;
  logic                   CS;
  logic                   COPI;
  logic                   HALT;
  logic                   CIPO;
  logic [motor_count-1:0] STEPOUTPUT;
  logic [motor_count-1:0] DIROUTPUT;
  logic [motor_count-1:0] ENOUTPUT;
  logic                   BUFFER_DTR;
  logic                   MOVE_DONE;

  logic [31:0]            lcg_state = 32'hc59b6adb;
  int                     step_count [motor_count];
  int                     done_seen;
  int                     moves_sent;
  logic                   saw_full;      // BUFFER_DTR went low at some point
  logic [31:0]            exp_dur_q [$];
  logic [motor_count-1:0] exp_dir_q [$];
  logic [31:0]            exp_incr_q [$];  // motor_count entries per move

  tb_clock_gen u_clock_gen (
    .CLK    (CLK),
    .resetn (resetn)
  );

  rapcore u_rapcore (.*);

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Carries out of a 32-bit accumulator after duration adds of incr
  function automatic logic [31:0] expected_steps(input logic [31:0] incr,
                                                 input logic [31:0] duration);
    logic [63:0] product;
    product = {32'd0, incr} * {32'd0, duration};
    return product[63:32];
  endfunction

  // LSB byte first, MSB bit first within a byte
  function automatic int wire_bit(input int pos);
    return (pos / 8) * 8 + 7 - (pos % 8);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge CLK);
    #1;  // Drive point
  endtask

  task automatic send_word(input logic [63:0] tx, output logic [63:0] rx);
    int idx;
    rx = '0;
    CS = 1'b0;
    wait_clocks(half_clks);
    for (int pos = 0; pos < 64; pos++) begin
      idx = wire_bit(pos);
      COPI = tx[idx];
      wait_clocks(half_clks);
      rx[idx] = CIPO;  // Sampled just before the rising edge
      SCK = 1'b1;
      wait_clocks(half_clks);
      SCK = 1'b0;
    end
    wait_clocks(half_clks);
    CS = 1'b1;
    COPI = 1'b0;
    wait_clocks(2 * half_clks);  // Covers the req/ack round trip
  endtask

  task automatic wait_moves_done(input int target);
    int cycles;
    cycles = 0;
    while (done_seen < target) begin
      if (cycles > limit) begin
        abort_run($sformatf("timeout waiting for %0d completed moves", target));
      end
      wait_clocks(1);
      cycles++;
    end
  endtask

  task automatic send_random_move(input logic [31:0] duration);
    logic [63:0] reply;
    logic [63:0] header;
    logic [31:0] rnd;
    logic [31:0] incr [motor_count];
    int          cycles;
    rnd = next_random();
    header = {duration, 16'd0, 8'(rnd[motor_count-1:0]), 8'(cmd_move)};
    for (int m = 0; m < motor_count; m++) begin
      incr[m] = next_random() >> 1;  // Below 2^31
      exp_incr_q.push_back(incr[m]);
    end
    exp_dur_q.push_back(duration);
    exp_dir_q.push_back(rnd[motor_count-1:0]);
    cycles = 0;
    while (BUFFER_DTR !== 1'b1) begin
      if (cycles > limit) begin
        abort_run("timeout waiting for BUFFER_DTR before a move header");
      end
      wait_clocks(1);
      cycles++;
    end
    send_word(header, reply);
    for (int m = 0; m < motor_count; m++) begin
      send_word({32'd0, incr[m]}, reply);
    end
    moves_sent++;
  endtask

  task automatic check_status(input string name, input int fill, input int busy,
                              input int done);
    logic [63:0] reply;
    send_word({56'd0, 8'(cmd_status)}, reply);
    check_value({name, " fill"}, 64'(fill), 64'(reply[7:0]));
    check_value({name, " busy"}, 64'(busy), 64'(reply[8]));
    check_value({name, " moves done"}, 64'(done), 64'(reply[47:16]));
  endtask

  task automatic compare_move();
    logic [31:0]            duration;
    logic [31:0]            incr;
    logic [motor_count-1:0] dirs;
    duration = exp_dur_q.pop_front();
    dirs = exp_dir_q.pop_front();
    check_value($sformatf("move %0d direction", done_seen), 64'(dirs), 64'(DIROUTPUT));
    for (int m = 0; m < motor_count; m++) begin
      incr = exp_incr_q.pop_front();
      check_value($sformatf("move %0d motor %0d steps", done_seen, m),
                  64'(expected_steps(incr, duration)), 64'(step_count[m]));
      step_count[m] = 0;
    end
    done_seen++;
  endtask

  // Outputs settle by the falling edge
  always @(negedge CLK) begin
    if (resetn === 1'b1) begin
      if (BUFFER_DTR === 1'b0) begin
        saw_full = 1'b1;
      end
      for (int m = 0; m < motor_count; m++) begin
        if (STEPOUTPUT[m]) begin
          step_count[m]++;
        end
      end
      if (STEPOUTPUT != '0 && exp_dir_q.size() == 0) begin
        abort_run("step pulse seen with no move pending");
      end else if (STEPOUTPUT != '0) begin
        check_value("direction during move", 64'(exp_dir_q[0]), 64'(DIROUTPUT));
      end
      if (MOVE_DONE && exp_dur_q.size() == 0) begin
        abort_run("MOVE_DONE pulse seen with no move pending");
      end else if (MOVE_DONE) begin
        compare_move();
      end
    end
  end

  initial begin
    logic [63:0] reply;
    logic [31:0] rnd;
    int          cycles;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    HALT = 1'b0;
    done_seen = 0;
    moves_sent = 0;
    saw_full = 1'b0;
    foreach (step_count[m]) begin
      step_count[m] = 0;
    end
    cycles = 0;
    while (resetn !== 1'b1) begin
      if (cycles > 100) begin
        abort_run("reset was never released");
      end
      wait_clocks(1);
      cycles++;
    end
    wait_clocks(2);

    check_value("reset step", 0, 64'(STEPOUTPUT));
    check_value("reset enable", 0, 64'(ENOUTPUT));
    check_value("reset move done", 0, 64'(MOVE_DONE));
    check_value("reset buffer dtr", 1, 64'(BUFFER_DTR));
    check_status("reset", 0, 0, 0);

    rnd = next_random();
    send_word({48'd0, 8'(rnd[motor_count-1:0]), 8'(cmd_enable)}, reply);
    check_value("enable mask", 64'(rnd[motor_count-1:0]), 64'(ENOUTPUT));

    for (int n = 0; n < 4; n++) begin  // Single short moves
      rnd = next_random();
      send_random_move(32'd50 + rnd % 200);
      wait_moves_done(moves_sent);
    end

    // Long enough that the FIFO fills while later moves are sent
    for (int n = 0; n <= buffer_size; n++) begin
      rnd = next_random();
      send_random_move(32'd12000 + rnd % 4096);
    end
    wait_moves_done(moves_sent);
    check_value("buffer filled", 1, 64'(saw_full));
    check_status("after queue", 0, 0, moves_sent);

    send_random_move(32'd200000);
    send_random_move(32'd100);
    send_random_move(32'd100);
    check_status("before halt", 2, 1, moves_sent - 3);
    HALT = 1'b1;
    exp_dur_q.delete();
    exp_dir_q.delete();
    exp_incr_q.delete();
    foreach (step_count[m]) begin
      step_count[m] = 0;
    end
    wait_clocks(1);
    HALT = 1'b0;
    for (int n = 0; n < 200; n++) begin
      @(negedge CLK);
      check_value("step after halt", 0, 64'(STEPOUTPUT));
      check_value("done after halt", 0, 64'(MOVE_DONE));
    end
    wait_clocks(1);
    check_status("after halt", 0, 0, moves_sent - 3);
    check_value("moves completed before halt", 64'(moves_sent - 3), 64'(done_seen));

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
rapcore_pkg.sv
spi_word.sv
command_decoder.sv
move_buffer.sv
step_generator.sv
rapcore.sv
tb_clock_gen.sv
tb_rapcore.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the run
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_rapcore -o tb_rapcore
./obj_dir/tb_rapcore
